//--- design/exu_pkg.sv
////////////////////
// shared widths, op encoding and stage payloads for the integer execute slice
// used by the RTL and the testbench through scoped names
////////////////////

package exu_pkg;

    // datapath and register file widths
    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;
    // default only, the top level sets the real value
    localparam int unsigned commit_id_w = 3;

    // one-hot bit positions
    localparam int unsigned op_add_idx   = 0;
    localparam int unsigned op_sub_idx   = 1;
    localparam int unsigned op_sll_idx   = 2;
    localparam int unsigned op_slt_idx   = 3;
    localparam int unsigned op_sltu_idx  = 4;
    localparam int unsigned op_xor_idx   = 5;
    localparam int unsigned op_srl_idx   = 6;
    localparam int unsigned op_sra_idx   = 7;
    localparam int unsigned op_or_idx    = 8;
    localparam int unsigned op_and_idx   = 9;
    localparam int unsigned op_lui_idx   = 10;
    localparam int unsigned op_auipc_idx = 11;
    localparam int unsigned op_jump_idx  = 12;
    localparam int unsigned alu_op_w     = 13;

    // one bit per alu function
    typedef enum logic [alu_op_w-1:0] {
        alu_add   = 13'(1) << op_add_idx,
        alu_sub   = 13'(1) << op_sub_idx,
        alu_sll   = 13'(1) << op_sll_idx,
        alu_slt   = 13'(1) << op_slt_idx,
        alu_sltu  = 13'(1) << op_sltu_idx,
        alu_xor   = 13'(1) << op_xor_idx,
        alu_srl   = 13'(1) << op_srl_idx,
        alu_sra   = 13'(1) << op_sra_idx,
        alu_or    = 13'(1) << op_or_idx,
        alu_and   = 13'(1) << op_and_idx,
        alu_lui   = 13'(1) << op_lui_idx,
        alu_auipc = 13'(1) << op_auipc_idx,
        alu_jump  = 13'(1) << op_jump_idx
    } alu_op_e;

    // dispatched request, also the issue stage contents
    typedef struct packed {
        logic                   valid;
        logic [xlen-1:0]        op1;
        logic [xlen-1:0]        op2;
        alu_op_e                op;
        logic [reg_addr_w-1:0]  rd;
        logic                   reg_we;
        logic [commit_id_w-1:0] commit_id;
    } issue_t;

    // writeback payload, also the result stage contents
    typedef struct packed {
        logic                   valid;
        logic [xlen-1:0]        result;
        logic [reg_addr_w-1:0]  rd;
        logic [commit_id_w-1:0] commit_id;
    } wb_t;

endpackage

//--- design/exu_alu_adder.sv
////////////////////
// adder datapath of one alu lane
// add, sub, slt, sltu, auipc and jump link share a single carry chain
////////////////////
`timescale 1ns/100ps

module exu_alu_adder (
    input  logic [exu_pkg::xlen-1:0] op1_i,
    input  logic [exu_pkg::xlen-1:0] op2_i,
    input  exu_pkg::alu_op_e         op_i,
    output logic [exu_pkg::xlen-1:0] result_o
);

    localparam int unsigned w = exu_pkg::xlen;

    logic         do_sub;
    logic [w-1:0] op2_eff;
    logic [w:0]   sum_ext;
    logic [w-1:0] sum;
    logic         overflow;
    logic         lt_signed;
    logic         lt_unsigned;

    // compares are a subtraction too
    assign do_sub = op_i[exu_pkg::op_sub_idx]
                  | op_i[exu_pkg::op_slt_idx]
                  | op_i[exu_pkg::op_sltu_idx];

    // invert and add one for the difference
    assign op2_eff = do_sub ? ~op2_i : op2_i;
    assign sum_ext = {1'b0, op1_i} + {1'b0, op2_eff} + {{w{1'b0}}, do_sub};
    assign sum     = sum_ext[w-1:0];

    // operands differ in sign and the sign of the result flips
    assign overflow  = (op1_i[w-1] != op2_i[w-1]) && (sum[w-1] != op1_i[w-1]);
    assign lt_signed = sum[w-1] ^ overflow;
    // no carry out means a borrow
    assign lt_unsigned = ~sum_ext[w];

    // auipc and jump get pc and imm or four from dispatch, plain sum
    always_comb begin
        if (op_i[exu_pkg::op_slt_idx]) begin
            result_o = {{(w-1){1'b0}}, lt_signed};
        end else if (op_i[exu_pkg::op_sltu_idx]) begin
            result_o = {{(w-1){1'b0}}, lt_unsigned};
        end else begin
            result_o = sum;
        end
    end

endmodule

//--- design/exu_alu_shifter.sv
////////////////////
// shift and logic datapath of one alu lane
// one right shifter, sll runs through it bit-reversed
////////////////////
`timescale 1ns/100ps

module exu_alu_shifter (
    input  logic [exu_pkg::xlen-1:0] op1_i,
    input  logic [exu_pkg::xlen-1:0] op2_i,
    input  exu_pkg::alu_op_e         op_i,
    output logic [exu_pkg::xlen-1:0] result_o
);

    localparam int unsigned w     = exu_pkg::xlen;
    localparam int unsigned amt_w = $clog2(w);

    logic [amt_w-1:0] shamt;
    logic             is_sll;
    logic             fill;
    logic [w-1:0]     shift_in;
    logic [w-1:0]     shift_out;
    logic [w:0]       shift_ext;
    logic [w-1:0]     shift_res;

    assign shamt  = op2_i[amt_w-1:0];
    assign is_sll = op_i[exu_pkg::op_sll_idx];
    // sign fill only for sra
    assign fill   = op_i[exu_pkg::op_sra_idx] & op1_i[w-1];

    // left shift is a right shift of the mirrored word
    always_comb begin
        for (int i = 0; i < w; i++) begin
            shift_in[i] = is_sll ? op1_i[w-1-i] : op1_i[i];
        end
    end

    // extra top bit carries the fill value
    assign shift_ext = $signed({fill, shift_in}) >>> shamt;
    assign shift_out = shift_ext[w-1:0];

    // mirror back for sll
    always_comb begin
        for (int i = 0; i < w; i++) begin
            shift_res[i] = is_sll ? shift_out[w-1-i] : shift_out[i];
        end
    end

    // and-or select, op is one-hot
    assign result_o = ({w{op_i[exu_pkg::op_xor_idx]}} & (op1_i ^ op2_i))
                    | ({w{op_i[exu_pkg::op_or_idx]}}  & (op1_i | op2_i))
                    | ({w{op_i[exu_pkg::op_and_idx]}} & (op1_i & op2_i))
                    | ({w{is_sll | op_i[exu_pkg::op_srl_idx]
                           | op_i[exu_pkg::op_sra_idx]}} & shift_res);

endmodule

//--- design/exu_pipe_reg.sv
////////////////////
// pipeline register for one stage payload
// load captures, kill empties the stage
////////////////////
`timescale 1ns/100ps

module exu_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     load_i,
    input  logic     kill_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t q;

    // kill wins over load, clears the valid field with the rest
    always_ff @(posedge clk) begin
        if (!rst_n_i || kill_i) begin
            q <= '0;
        end else if (load_i) begin
            q <= d_i;
        end
    end

    assign q_o = q;

endmodule

//--- design/exu_alu_ctrl.sv
////////////////////
// lane control for the two stage alu pipe
// decides acceptance, stage loads, kill and the stall flag back to dispatch
////////////////////
`timescale 1ns/100ps

module exu_alu_ctrl #(
    parameter int unsigned commit_id_w = exu_pkg::commit_id_w
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic issue_valid_i,
    input  logic stall_i,
    input  logic flush_i,
    input  logic int_assert_i,
    input  logic iss_valid_i,
    input  logic wb_valid_i,
    input  logic wb_ready_i,
    output logic accept_o,
    output logic iss_load_o,
    output logic wb_load_o,
    output logic kill_o,
    output logic alu_stall_o
);

    // two ops in flight need two distinct commit ids
    localparam int unsigned max_in_flight = 2;

    if ((64'd1 << commit_id_w) < max_in_flight) begin : g_cid_check
        $error("commit id too narrow for two ops in flight");
    end

    logic res_free;
    logic iss_full_q;

    // result stage empty or handing off this edge
    assign res_free = !wb_valid_i || wb_ready_i;

    // freeze stops both stages
    assign wb_load_o  = res_free && !stall_i;
    assign iss_load_o = !stall_i && (!iss_valid_i || res_free);

    // int_assert only drops this cycle's request
    assign accept_o = issue_valid_i && iss_load_o && !flush_i && !int_assert_i;

    assign kill_o = flush_i;

    // occupancy of the issue stage, tracked here for the stall flag
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            iss_full_q <= 1'b0;
        end else if (iss_load_o) begin
            iss_full_q <= accept_o;
        end
    end

    // full issue stage behind a blocked result stage
    // stall_i is left out, dispatch sees it directly
    assign alu_stall_o = iss_full_q && !res_free;

endmodule

//--- design/exu_alu.sv
////////////////////
// one alu lane, issue stage then result stage
// writeback leaves in acceptance order, two ops in flight at most
////////////////////
`timescale 1ns/100ps

module exu_alu #(
    parameter int unsigned commit_id_w = exu_pkg::commit_id_w
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  exu_pkg::issue_t issue_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic            int_assert_i,
    input  logic            wb_ready_i,
    output exu_pkg::wb_t    wb_o,
    output logic            alu_stall_o
);

    localparam int unsigned w = exu_pkg::xlen;

    // payload structs carry the package width
    if (commit_id_w != exu_pkg::commit_id_w) begin : g_cid_check
        $error("commit_id_w differs from the payload structs");
    end

    logic                   accept;
    logic                   iss_load;
    logic                   wb_load;
    logic                   kill;
    exu_pkg::issue_t        iss_d;
    exu_pkg::issue_t        iss_q;
    exu_pkg::wb_t           wb_d;
    exu_pkg::wb_t           wb_q;
    logic [w-1:0]           adder_res;
    logic [w-1:0]           shifter_res;
    logic                   sel_adder;
    logic                   sel_shifter;
    logic                   sel_lui;
    logic [w-1:0]           alu_res;
    logic [commit_id_w-1:0] iss_cid;

    exu_alu_ctrl #(
        .commit_id_w(commit_id_w)
    ) u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .issue_valid_i(issue_i.valid),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .int_assert_i (int_assert_i),
        .iss_valid_i  (iss_q.valid),
        .wb_valid_i   (wb_q.valid),
        .wb_ready_i   (wb_ready_i),
        .accept_o     (accept),
        .iss_load_o   (iss_load),
        .wb_load_o    (wb_load),
        .kill_o       (kill),
        .alu_stall_o  (alu_stall_o)
    );

    // a bubble enters when nothing is accepted
    always_comb begin
        iss_d       = issue_i;
        iss_d.valid = accept;
    end

    exu_pipe_reg #(
        .payload_t(exu_pkg::issue_t)
    ) u_iss_stage (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .load_i (iss_load),
        .kill_i (kill),
        .d_i    (iss_d),
        .q_o    (iss_q)
    );

    // datapaths work on the issue stage contents
    exu_alu_adder u_adder (
        .op1_i   (iss_q.op1),
        .op2_i   (iss_q.op2),
        .op_i    (iss_q.op),
        .result_o(adder_res)
    );

    exu_alu_shifter u_shifter (
        .op1_i   (iss_q.op1),
        .op2_i   (iss_q.op2),
        .op_i    (iss_q.op),
        .result_o(shifter_res)
    );

    assign sel_adder = iss_q.op[exu_pkg::op_add_idx] | iss_q.op[exu_pkg::op_sub_idx]
                     | iss_q.op[exu_pkg::op_slt_idx] | iss_q.op[exu_pkg::op_sltu_idx]
                     | iss_q.op[exu_pkg::op_auipc_idx] | iss_q.op[exu_pkg::op_jump_idx];
    assign sel_shifter = iss_q.op[exu_pkg::op_sll_idx] | iss_q.op[exu_pkg::op_srl_idx]
                       | iss_q.op[exu_pkg::op_sra_idx] | iss_q.op[exu_pkg::op_xor_idx]
                       | iss_q.op[exu_pkg::op_or_idx]  | iss_q.op[exu_pkg::op_and_idx];
    // lui: dispatch puts the shifted immediate in op2
    assign sel_lui = iss_q.op[exu_pkg::op_lui_idx];

    assign alu_res = ({w{sel_adder}}   & adder_res)
                   | ({w{sel_shifter}} & shifter_res)
                   | ({w{sel_lui}}     & iss_q.op2);

    assign iss_cid = iss_q.commit_id;

    // no writeback for reg_we low or x0
    always_comb begin
        wb_d.valid     = iss_q.valid && iss_q.reg_we && (iss_q.rd != '0);
        wb_d.result    = alu_res;
        wb_d.rd        = iss_q.rd;
        wb_d.commit_id = iss_cid;
    end

    // held while wb_ready is low
    exu_pipe_reg #(
        .payload_t(exu_pkg::wb_t)
    ) u_wb_stage (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .load_i (wb_load),
        .kill_i (kill),
        .d_i    (wb_d),
        .q_o    (wb_q)
    );

    assign wb_o = wb_q;

endmodule

//--- design/exu_alu_dual.sv
////////////////////
// dual-issue execute slice, two independent alu lanes
// freeze, flush and interrupt kill come from the control unit to both
////////////////////
`timescale 1ns/100ps

module exu_alu_dual #(
    parameter int unsigned commit_id_w = exu_pkg::commit_id_w
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic            int_assert_i,
    // lane 0
    input  exu_pkg::issue_t issue_0_i,
    input  logic            wb_ready_0_i,
    output exu_pkg::wb_t    wb_0_o,
    output logic            alu_stall_0_o,
    // lane 1
    input  exu_pkg::issue_t issue_1_i,
    input  logic            wb_ready_1_i,
    output exu_pkg::wb_t    wb_1_o,
    output logic            alu_stall_1_o
);

    exu_alu #(
        .commit_id_w(commit_id_w)
    ) u_alu_0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .issue_i     (issue_0_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .int_assert_i(int_assert_i),
        .wb_ready_i  (wb_ready_0_i),
        .wb_o        (wb_0_o),
        .alu_stall_o (alu_stall_0_o)
    );

    exu_alu #(
        .commit_id_w(commit_id_w)
    ) u_alu_1 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .issue_i     (issue_1_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .int_assert_i(int_assert_i),
        .wb_ready_i  (wb_ready_1_i),
        .wb_o        (wb_1_o),
        .alu_stall_o (alu_stall_1_o)
    );

endmodule

//--- dv/exu_properties.sv
////////////////////
// handshake and reset assertions for one alu lane
// bound into every exu_alu instance by the testbench top
////////////////////
`timescale 1ns/100ps

module exu_properties (
    input logic            clk,
    input logic            rst_n_i,
    input logic            flush_i,
    input logic            wb_ready_i,
    input exu_pkg::wb_t    wb_i,
    input logic            alu_stall_i,
    input exu_pkg::issue_t iss_i
);

    // count of failed assertions
    int fails = 0;

    // blocked writeback keeps its payload unless killed
    a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_i.valid && !wb_ready_i && !flush_i |=> $stable(wb_i))
        else begin
            fails++;
            $error("wb_o changed while valid and not ready");
        end

    // a reset edge leaves the lane empty and not stalling
    a_reset_idle: assert property (@(posedge clk)
        !rst_n_i |=> !alu_stall_i && !wb_i.valid)
        else begin
            fails++;
            $error("alu_stall_o or wb_o.valid high after reset");
        end

    // nothing enters the issue stage on a flush edge
    a_flush_no_accept: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !iss_i.valid)
        else begin
            fails++;
            $error("request entered the issue stage while flush_i was high");
        end

endmodule

//--- dv/exu_checker.sv
////////////////////
// scoreboard for one alu lane
// predicts each accepted writeback and compares it when it is handed off
////////////////////
`timescale 1ns/100ps

module exu_checker #(
    parameter int lane = 0
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic            int_assert_i,
    input  exu_pkg::issue_t issue_i,
    input  logic            alu_stall_i,
    input  logic            wb_ready_i,
    input  exu_pkg::wb_t    wb_i,
    input  logic            check_latency_i,
    output int              errors_o,
    output int              transfers_o,
    output int              pending_o
);

    localparam int w = exu_pkg::xlen;

    exu_pkg::wb_t exp_q[$];
    int           acc_cyc_q[$];
    int           cyc = 0;
    int           errors = 0;
    int           transfers = 0;
    int           pending = 0;
    exu_pkg::wb_t wb_prev;
    logic         hold_prev = 1'b0;
    logic         iss_busy = 1'b0;
    logic         res_blocked;
    logic         stall_exp;

    // rv32i results, shift amount is the low five bits of op2
    function automatic logic [w-1:0] alu_ref(input exu_pkg::alu_op_e op,
                                             input logic [w-1:0] a, input logic [w-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            exu_pkg::alu_add:   return a + b;
            exu_pkg::alu_sub:   return a - b;
            exu_pkg::alu_sll:   return a << sh;
            exu_pkg::alu_slt:   return {{(w-1){1'b0}}, $signed(a) < $signed(b)};
            exu_pkg::alu_sltu:  return {{(w-1){1'b0}}, a < b};
            exu_pkg::alu_xor:   return a ^ b;
            exu_pkg::alu_srl:   return a >> sh;
            exu_pkg::alu_sra:   return $signed(a) >>> sh;
            exu_pkg::alu_or:    return a | b;
            exu_pkg::alu_and:   return a & b;
            exu_pkg::alu_lui:   return b;
            // pc in op1, immediate or four in op2
            exu_pkg::alu_auipc: return a + b;
            exu_pkg::alu_jump:  return a + b;
            default:            return '0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [w-1:0] got, input logic [w-1:0] want);
        if (got !== want) begin
            errors++;
            $display("MISMATCH lane%0d %s: got %h expected %h", lane, name, got, want);
        end
    endtask

    always @(posedge clk) begin
        exu_pkg::wb_t want;
        int           lat;
        if (!rst_n_i) begin
            exp_q.delete();
            acc_cyc_q.delete();
            hold_prev = 1'b0;
            iss_busy = 1'b0;
            cyc = 0;
        end else begin
            cyc++;
            // blocked or frozen result stage
            if (hold_prev && wb_i !== wb_prev) begin
                errors++;
                $display("MISMATCH lane%0d wb_o while held: got %h expected %h",
                         lane, wb_i, wb_prev);
            end
            // full issue stage behind a blocked result stage
            res_blocked = wb_i.valid && !wb_ready_i;
            stall_exp   = iss_busy && res_blocked;
            if (alu_stall_i !== stall_exp) begin
                errors++;
                $display("MISMATCH lane%0d alu_stall_o: got %h expected %h",
                         lane, alu_stall_i, stall_exp);
            end
            // no hand-off while frozen
            if (wb_i.valid && wb_ready_i && !stall_i) begin
                transfers++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("lane%0d: writeback to x%0d with commit id %0d was not expected",
                             lane, wb_i.rd, wb_i.commit_id);
                end else begin
                    want = exp_q.pop_front();
                    lat = cyc - acc_cyc_q.pop_front();
                    compare("wb_o.result", wb_i.result, want.result);
                    compare("wb_o.rd", w'(wb_i.rd), w'(want.rd));
                    compare("wb_o.commit_id", w'(wb_i.commit_id), w'(want.commit_id));
                    if (check_latency_i && lat != 2) begin
                        errors++;
                        $display("lane%0d: commit id %0d arrived %0d edges after acceptance, not 2",
                                 lane, want.commit_id, lat);
                    end
                end
            end
            if (flush_i) begin
                // in-flight ops die
                exp_q.delete();
                acc_cyc_q.delete();
            end else if (issue_i.valid && !alu_stall_i && !stall_i && !int_assert_i) begin
                // accepted, writeback only for a real destination
                if (issue_i.reg_we && issue_i.rd != '0) begin
                    want.valid     = 1'b1;
                    want.result    = alu_ref(issue_i.op, issue_i.op1, issue_i.op2);
                    want.rd        = issue_i.rd;
                    want.commit_id = issue_i.commit_id;
                    exp_q.push_back(want);
                    acc_cyc_q.push_back(cyc);
                end
            end
            // issue stage occupancy, advances unless frozen or blocked
            if (flush_i) begin
                iss_busy = 1'b0;
            end else if (!stall_i && (!iss_busy || !res_blocked)) begin
                iss_busy = issue_i.valid && !int_assert_i;
            end
            hold_prev = !flush_i && (stall_i || (wb_i.valid && !wb_ready_i));
            wb_prev = wb_i;
        end
        pending = exp_q.size();
    end

    assign errors_o    = errors;
    assign transfers_o = transfers;
    assign pending_o   = pending;

endmodule

//--- dv/tb_exu.sv
////////////////////
// testbench for the dual alu execute slice
// drives both lanes as a dispatcher would, reports per test and a verdict
////////////////////
`timescale 1ns/100ps

module tb_exu;

    localparam int n_tests      = 6;
    localparam int ops_per_test = 60;
    // worst case edges per op under back-pressure, freeze and kills
    localparam int stall_allow  = 20;
    localparam int wd_cycles    = n_tests * ops_per_test * stall_allow;
    localparam int drain_limit  = 50;
    localparam int cid_w        = exu_pkg::commit_id_w;

    logic            clk;
    logic            rst_n;
    logic            stall;
    logic            flush;
    logic            int_assert;
    logic            check_latency;
    exu_pkg::issue_t issue [2];
    logic            wb_ready [2];
    exu_pkg::wb_t    wb [2];
    logic            alu_stall [2];
    int              chk_errors [2];
    int              chk_xfers [2];
    int              pending [2];
    logic [cid_w-1:0] next_cid [2];
    int              tb_errors = 0;
    int              failed_tests = 0;
    int              err_mark = 0;
    int              xfer_mark = 0;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    exu_alu_dual #(
        .commit_id_w(cid_w)
    ) i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .stall_i      (stall),
        .flush_i      (flush),
        .int_assert_i (int_assert),
        .issue_0_i    (issue[0]),
        .wb_ready_0_i (wb_ready[0]),
        .wb_0_o       (wb[0]),
        .alu_stall_0_o(alu_stall[0]),
        .issue_1_i    (issue[1]),
        .wb_ready_1_i (wb_ready[1]),
        .wb_1_o       (wb[1]),
        .alu_stall_1_o(alu_stall[1])
    );

    for (genvar l = 0; l < 2; l++) begin : g_chk
        exu_checker #(
            .lane(l)
        ) i_chk (
            .clk            (clk),
            .rst_n_i        (rst_n),
            .stall_i        (stall),
            .flush_i        (flush),
            .int_assert_i   (int_assert),
            .issue_i        (issue[l]),
            .alu_stall_i    (alu_stall[l]),
            .wb_ready_i     (wb_ready[l]),
            .wb_i           (wb[l]),
            .check_latency_i(check_latency),
            .errors_o       (chk_errors[l]),
            .transfers_o    (chk_xfers[l]),
            .pending_o      (pending[l])
        );
    end

    bind exu_alu exu_properties u_props (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .wb_ready_i (wb_ready_i),
        .wb_i       (wb_o),
        .alu_stall_i(alu_stall_o),
        .iss_i      (iss_q)
    );

    // corners often, random otherwise
    function automatic logic [exu_pkg::xlen-1:0] pick_operand();
        case ($urandom_range(7))
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            3:       return 32'd31;
            default: return $urandom();
        endcase
    endfunction

    function automatic exu_pkg::issue_t new_request(input int lane, input int seq,
                                                    input bit cycle_ops);
        exu_pkg::issue_t req;
        int              op_idx;
        if (cycle_ops) begin
            op_idx = seq % 13;
        end else begin
            op_idx = int'($urandom_range(12));
        end
        req.valid = 1'b1;
        req.op    = exu_pkg::alu_op_e'(13'(1) << op_idx);
        req.op1   = pick_operand();
        req.op2   = pick_operand();
        // link is pc plus four, lui carries the upper immediate
        if (req.op == exu_pkg::alu_jump) begin
            req.op2 = 32'd4;
        end
        if (req.op == exu_pkg::alu_lui) begin
            req.op2[11:0] = '0;
        end
        req.rd        = ($urandom_range(7) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
        req.reg_we    = $urandom_range(7) != 0;
        req.commit_id = next_cid[lane];
        next_cid[lane] = next_cid[lane] + 1'b1;
        return req;
    endfunction

    function automatic int error_total();
        return chk_errors[0] + chk_errors[1] + tb_errors
             + i_dut.u_alu_0.u_props.fails + i_dut.u_alu_1.u_props.fails;
    endfunction

    // idle inputs, then wait for every predicted writeback
    task automatic drain();
        int waited;
        waited = 0;
        stall = 1'b0;
        flush = 1'b0;
        int_assert = 1'b0;
        for (int l = 0; l < 2; l++) begin
            wb_ready[l] = 1'b1;
            issue[l] = '0;
        end
        @(negedge clk);
        while ((pending[0] != 0 || pending[1] != 0 || wb[0].valid || wb[1].valid)
               && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= drain_limit) begin
            tb_errors++;
            $display("results still outstanding %0d cycles after the last request", drain_limit);
        end
    endtask

    task automatic run_traffic(input int n_ops, input int ready_pct, input int int_pct,
                               input int stall_pct, input int flush_at, input bit cycle_ops);
        int sent [2];
        bit take [2];
        int cyc;
        cyc = 0;
        @(posedge clk);
        #10;
        for (int l = 0; l < 2; l++) begin
            sent[l] = 0;
            issue[l] = new_request(l, 0, cycle_ops);
        end
        while (sent[0] < n_ops || sent[1] < n_ops) begin
            @(posedge clk);
            // dispatcher view of acceptance
            for (int l = 0; l < 2; l++) begin
                take[l] = issue[l].valid && !alu_stall[l] && !stall && !flush && !int_assert;
                if (take[l]) begin
                    sent[l]++;
                end
            end
            #10;
            cyc++;
            for (int l = 0; l < 2; l++) begin
                if (take[l] && sent[l] < n_ops) begin
                    issue[l] = new_request(l, sent[l], cycle_ops);
                end else if (take[l]) begin
                    issue[l] = '0;
                end
                wb_ready[l] = int'($urandom_range(99)) < ready_pct;
            end
            stall = int'($urandom_range(99)) < stall_pct;
            int_assert = int'($urandom_range(99)) < int_pct;
            flush = (cyc == flush_at);
            // nothing hands off on the flush edge
            if (flush) begin
                wb_ready[0] = 1'b0;
                wb_ready[1] = 1'b0;
            end
        end
        drain();
    endtask

    task automatic finish_test(input int num, input string name);
        int errs;
        int xfers;
        errs  = error_total() - err_mark;
        xfers = chk_xfers[0] + chk_xfers[1] - xfer_mark;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d writebacks, %0d errors", num, name, xfers, errs);
        err_mark  = error_total();
        xfer_mark = chk_xfers[0] + chk_xfers[1];
    endtask

    initial begin
        void'($urandom(32'h9892));
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        int_assert = 1'b0;
        check_latency = 1'b0;
        for (int l = 0; l < 2; l++) begin
            issue[l] = '0;
            wb_ready[l] = 1'b1;
            next_cid[l] = '0;
        end
        repeat (16) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        for (int l = 0; l < 2; l++) begin
            if (wb[l].valid !== 1'b0) begin
                tb_errors++;
                $display("MISMATCH lane%0d wb_o.valid after reset: got %h expected 0",
                         l, wb[l].valid);
            end
            if (alu_stall[l] !== 1'b0) begin
                tb_errors++;
                $display("MISMATCH lane%0d alu_stall_o after reset: got %h expected 0",
                         l, alu_stall[l]);
            end
        end
        finish_test(1, "reset state");
        check_latency = 1'b1;
        run_traffic(ops_per_test, 100, 0, 0, -1, 1'b1);
        check_latency = 1'b0;
        finish_test(2, "all ops");
        run_traffic(ops_per_test, 50, 0, 0, -1, 1'b0);
        finish_test(3, "writeback back-pressure");
        run_traffic(ops_per_test, 80, 0, 0, 25, 1'b0);
        finish_test(4, "flush");
        run_traffic(ops_per_test, 80, 25, 0, -1, 1'b0);
        finish_test(5, "interrupt kill");
        run_traffic(ops_per_test, 80, 0, 30, -1, 1'b0);
        finish_test(6, "freeze");
        $display("tests %0d, failed %0d, errors %0d", n_tests, failed_tests, error_total());
        if (failed_tests == 0 && error_total() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", wd_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- sim.f
design/exu_pkg.sv
design/exu_alu_adder.sv
design/exu_alu_shifter.sv
design/exu_pipe_reg.sv
design/exu_alu_ctrl.sv
design/exu_alu.sv
design/exu_alu_dual.sv
dv/exu_properties.sv
dv/exu_checker.sv
dv/tb_exu.sv

//--- Makefile
# Verilator build and run of the execute slice testbench

VERILATOR := verilator
TOP       := tb_exu
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert -Wno-fatal
RUN_FLAGS := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
